// ==== ant_sim_defines.svh ====
`ifndef ANT_SIM_DEFINES_SVH
`define ANT_SIM_DEFINES_SVH

// Number of ant records held by the datapath
`define NUM_ANT 4

// Visible screen in pixels
`define SCREEN_WIDTH  160
`define SCREEN_HEIGHT 120

// Sprite drawn around each ant position
`define ANT_WIDTH  3
`define ANT_HEIGHT 3

`define X_COORD_WIDTH 8
`define Y_COORD_WIDTH 8
`define COLOUR_WIDTH  3
`define ANT_COLOUR    3'b010

// Memory address is the ant index followed by the field bit, 0 for x and 1 for y
`define ID_WIDTH       2
`define MEM_ADDR_WIDTH 3

// Position of every ant after reset
`define ANT_RESET_X 8'd80
`define ANT_RESET_Y 8'd60

`define RESULT_WIDTH 8

`endif

// ==== ant_sim_pkg.sv ====
`include "ant_sim_defines.svh"

package ant_sim_pkg;

    typedef enum logic [1:0] {
        OP_NOP,
        OP_MEMREAD,
        OP_MEMWRITE,
        OP_DRAW
    } dp_opcode_e;

    // Fields unused by an opcode are left at zero
    typedef struct packed {
        dp_opcode_e                opcode;
        logic [`MEM_ADDR_WIDTH-1:0] addr;
        logic [`RESULT_WIDTH-1:0]   wdata;
        logic [`X_COORD_WIDTH-1:0]  draw_x;
        logic [`Y_COORD_WIDTH-1:0]  draw_y;
        logic [`COLOUR_WIDTH-1:0]   draw_colour;
    } instr_t;

    typedef enum logic [3:0] {
        D_STANDBY,
        D_LOAD_X_START, D_LOAD_X_DELAY, D_LOAD_X_WAIT,
        D_LOAD_Y_START, D_LOAD_Y_DELAY, D_LOAD_Y_WAIT,
        D_DRAW_START,   D_DRAW_DELAY,   D_DRAW_WAIT
    } draw_state_e;

    typedef enum logic [3:0] {
        U_STANDBY,
        U_LOAD_X_START, U_LOAD_X_DELAY, U_LOAD_X_WAIT,
        U_LOAD_Y_START, U_LOAD_Y_DELAY, U_LOAD_Y_WAIT,
        U_MOVE,
        U_SET_X_START,  U_SET_X_DELAY,  U_SET_X_WAIT,
        U_SET_Y_START,  U_SET_Y_DELAY,  U_SET_Y_WAIT
    } update_state_e;

endpackage

// ==== ant_draw.sv ====
`timescale 1ns/10ps
`include "ant_sim_defines.svh"

module ant_draw (
    input  logic                     clock,
    input  logic                     resetn,
    input  logic                     start,
    input  logic [`ID_WIDTH-1:0]     id,
    output logic                     finished,
    input  logic                     finished_dp,
    input  logic [`RESULT_WIDTH-1:0] result_dp,
    output logic                     start_dp,
    output ant_sim_pkg::instr_t      instruction_dp
);
    import ant_sim_pkg::*;

    draw_state_e state;

    logic [`ID_WIDTH-1:0]      id_q;
    // Top left corner of the sprite
    logic [`X_COORD_WIDTH-1:0] x;
    logic [`Y_COORD_WIDTH-1:0] y;
    logic [`X_COORD_WIDTH-1:0] dx;
    logic [`Y_COORD_WIDTH-1:0] dy;

    assign finished = (state == D_STANDBY);
    assign start_dp = state inside {D_LOAD_X_START, D_LOAD_X_DELAY, D_LOAD_Y_START,
                                    D_LOAD_Y_DELAY, D_DRAW_START, D_DRAW_DELAY};

    // Instruction follows the state so it stays put until the datapath takes it
    always_comb begin
        instruction_dp = '0;
        case (state)
            D_LOAD_X_START, D_LOAD_X_DELAY, D_LOAD_X_WAIT: begin
                instruction_dp.opcode = OP_MEMREAD;
                instruction_dp.addr   = {id_q, 1'b0};
            end
            D_LOAD_Y_START, D_LOAD_Y_DELAY, D_LOAD_Y_WAIT: begin
                instruction_dp.opcode = OP_MEMREAD;
                instruction_dp.addr   = {id_q, 1'b1};
            end
            D_DRAW_START, D_DRAW_DELAY, D_DRAW_WAIT: begin
                instruction_dp.opcode      = OP_DRAW;
                instruction_dp.draw_x      = x + dx;
                instruction_dp.draw_y      = y + dy;
                instruction_dp.draw_colour = `ANT_COLOUR;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= D_STANDBY;
        end else begin
            case (state)
                D_STANDBY: begin
                    if (start) begin
                        id_q  <= id;
                        dx    <= '0;
                        dy    <= '0;
                        state <= D_LOAD_X_START;
                    end
                end
                D_LOAD_X_START: state <= D_LOAD_X_DELAY;
                D_LOAD_X_DELAY: state <= D_LOAD_X_WAIT;
                D_LOAD_X_WAIT: begin
                    if (finished_dp) begin
                        x     <= result_dp - 1'b1;
                        state <= D_LOAD_Y_START;
                    end
                end
                D_LOAD_Y_START: state <= D_LOAD_Y_DELAY;
                D_LOAD_Y_DELAY: state <= D_LOAD_Y_WAIT;
                D_LOAD_Y_WAIT: begin
                    if (finished_dp) begin
                        y     <= result_dp - 1'b1;
                        state <= D_DRAW_START;
                    end
                end
                D_DRAW_START: state <= D_DRAW_DELAY;
                D_DRAW_DELAY: state <= D_DRAW_WAIT;
                D_DRAW_WAIT: begin
                    // Row by row, x fastest
                    if (finished_dp) begin
                        state <= D_DRAW_START;
                        if (dx == `ANT_WIDTH - 1) begin
                            dx <= '0;
                            if (dy == `ANT_HEIGHT - 1) begin
                                state <= D_STANDBY;
                            end else begin
                                dy <= dy + 1'b1;
                            end
                        end else begin
                            dx <= dx + 1'b1;
                        end
                    end
                end
                default: state <= D_STANDBY;
            endcase
        end
    end

    // Each request is exactly the START and DELAY cycles long
    assert property (@(posedge clock) disable iff (!resetn) start_dp [*2] |=> !start_dp);

endmodule

// ==== ant_update.sv ====
`timescale 1ns/10ps
`include "ant_sim_defines.svh"

module ant_update (
    input  logic                     clock,
    input  logic                     resetn,
    input  logic                     start,
    input  logic [`ID_WIDTH-1:0]     id,
    // Left, right, up, down
    input  logic [3:0]               move_request,
    output logic                     finished,
    input  logic                     finished_dp,
    input  logic [`RESULT_WIDTH-1:0] result_dp,
    output logic                     start_dp,
    output ant_sim_pkg::instr_t      instruction_dp
);
    import ant_sim_pkg::*;

    update_state_e state;

    logic [`ID_WIDTH-1:0]      id_q;
    logic [3:0]                move_q;
    logic [`X_COORD_WIDTH-1:0] x;
    logic [`Y_COORD_WIDTH-1:0] y;
    logic [`X_COORD_WIDTH-1:0] x_moved;
    logic [`Y_COORD_WIDTH-1:0] y_moved;

    assign finished = (state == U_STANDBY);
    assign start_dp = state inside {U_LOAD_X_START, U_LOAD_X_DELAY, U_LOAD_Y_START,
                                    U_LOAD_Y_DELAY, U_SET_X_START, U_SET_X_DELAY,
                                    U_SET_Y_START, U_SET_Y_DELAY};

    // Clamped move, right tested on the x already moved left
    always_comb begin
        x_moved = x;
        y_moved = y;
        if (move_q[3] && x_moved > (`ANT_WIDTH / 2))
            x_moved = x_moved - 1'b1;
        if (move_q[2] && x_moved < (`SCREEN_WIDTH - `ANT_WIDTH / 2 - 1))
            x_moved = x_moved + 1'b1;
        if (move_q[1] && y_moved > (`ANT_HEIGHT / 2))
            y_moved = y_moved - 1'b1;
        if (move_q[0] && y_moved < (`SCREEN_HEIGHT - `ANT_HEIGHT / 2 - 1))
            y_moved = y_moved + 1'b1;
    end

    always_comb begin
        instruction_dp = '0;
        case (state)
            U_LOAD_X_START, U_LOAD_X_DELAY, U_LOAD_X_WAIT: begin
                instruction_dp.opcode = OP_MEMREAD;
                instruction_dp.addr   = {id_q, 1'b0};
            end
            U_LOAD_Y_START, U_LOAD_Y_DELAY, U_LOAD_Y_WAIT: begin
                instruction_dp.opcode = OP_MEMREAD;
                instruction_dp.addr   = {id_q, 1'b1};
            end
            U_SET_X_START, U_SET_X_DELAY, U_SET_X_WAIT: begin
                instruction_dp.opcode = OP_MEMWRITE;
                instruction_dp.addr   = {id_q, 1'b0};
                instruction_dp.wdata  = x;
            end
            U_SET_Y_START, U_SET_Y_DELAY, U_SET_Y_WAIT: begin
                instruction_dp.opcode = OP_MEMWRITE;
                instruction_dp.addr   = {id_q, 1'b1};
                instruction_dp.wdata  = y;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= U_STANDBY;
        end else begin
            case (state)
                U_STANDBY: begin
                    if (start) begin
                        id_q   <= id;
                        move_q <= move_request;
                        state  <= U_LOAD_X_START;
                    end
                end
                U_LOAD_X_START: state <= U_LOAD_X_DELAY;
                U_LOAD_X_DELAY: state <= U_LOAD_X_WAIT;
                U_LOAD_X_WAIT: begin
                    if (finished_dp) begin
                        x     <= result_dp;
                        state <= U_LOAD_Y_START;
                    end
                end
                U_LOAD_Y_START: state <= U_LOAD_Y_DELAY;
                U_LOAD_Y_DELAY: state <= U_LOAD_Y_WAIT;
                U_LOAD_Y_WAIT: begin
                    if (finished_dp) begin
                        y     <= result_dp;
                        state <= U_MOVE;
                    end
                end
                U_MOVE: begin
                    x     <= x_moved;
                    y     <= y_moved;
                    state <= U_SET_X_START;
                end
                U_SET_X_START: state <= U_SET_X_DELAY;
                U_SET_X_DELAY: state <= U_SET_X_WAIT;
                U_SET_X_WAIT: begin
                    if (finished_dp)
                        state <= U_SET_Y_START;
                end
                U_SET_Y_START: state <= U_SET_Y_DELAY;
                U_SET_Y_DELAY: state <= U_SET_Y_WAIT;
                U_SET_Y_WAIT: begin
                    if (finished_dp)
                        state <= U_STANDBY;
                end
                default: state <= U_STANDBY;
            endcase
        end
    end

    // Stored x stays where the whole sprite is on screen
    assert property (@(posedge clock) disable iff (!resetn)
        (state == U_MOVE) |=>
            (x >= (`ANT_WIDTH / 2) && x <= (`SCREEN_WIDTH - `ANT_WIDTH / 2 - 1)));

endmodule

// ==== ant_datapath.sv ====
`timescale 1ns/10ps
`include "ant_sim_defines.svh"

module ant_datapath (
    input  logic                      clock,
    input  logic                      resetn,
    input  logic                      draw_start_dp,
    input  ant_sim_pkg::instr_t       draw_instruction,
    output logic                      draw_finished_dp,
    input  logic                      update_start_dp,
    input  ant_sim_pkg::instr_t       update_instruction,
    output logic                      update_finished_dp,
    output logic [`RESULT_WIDTH-1:0]  result_dp,
    output logic                      pixel_valid,
    output logic [`X_COORD_WIDTH-1:0] pixel_x,
    output logic [`Y_COORD_WIDTH-1:0] pixel_y,
    output logic [`COLOUR_WIDTH-1:0]  pixel_colour
);
    import ant_sim_pkg::*;

    // Even entries hold x, odd entries hold y
    logic [`RESULT_WIDTH-1:0] mem [0:2*`NUM_ANT-1];

    logic   draw_start_q;
    logic   update_start_q;
    logic   draw_pend;
    logic   update_pend;
    logic   draw_req;
    logic   update_req;
    logic   accept;
    logic   grant_update;
    logic   busy;
    logic   exec_cnt;
    logic   owner_update;
    instr_t cur_instr;

    assign draw_req     = (draw_start_dp && !draw_start_q) || draw_pend;
    assign update_req   = (update_start_dp && !update_start_q) || update_pend;
    assign accept       = !busy && (draw_req || update_req);
    // Draw client wins a tie
    assign grant_update = !draw_req;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            draw_start_q       <= 1'b0;
            update_start_q     <= 1'b0;
            draw_pend          <= 1'b0;
            update_pend        <= 1'b0;
            busy               <= 1'b0;
            exec_cnt           <= 1'b0;
            owner_update       <= 1'b0;
            draw_finished_dp   <= 1'b0;
            update_finished_dp <= 1'b0;
            pixel_valid        <= 1'b0;
            for (int i = 0; i < 2 * `NUM_ANT; i++) begin
                mem[i] <= (i % 2 == 0) ? `ANT_RESET_X : `ANT_RESET_Y;
            end
        end else begin
            draw_start_q       <= draw_start_dp;
            update_start_q     <= update_start_dp;
            draw_pend          <= draw_req && !(accept && !grant_update);
            update_pend        <= update_req && !(accept && grant_update);
            draw_finished_dp   <= 1'b0;
            update_finished_dp <= 1'b0;
            pixel_valid        <= 1'b0;
            if (accept) begin
                busy         <= 1'b1;
                exec_cnt     <= 1'b0;
                owner_update <= grant_update;
            end else if (busy) begin
                if (!exec_cnt) begin
                    // Execute, finish lands two cycles after acceptance
                    exec_cnt           <= 1'b1;
                    draw_finished_dp   <= !owner_update;
                    update_finished_dp <= owner_update;
                    pixel_valid        <= (cur_instr.opcode == OP_DRAW);
                    if (cur_instr.opcode == OP_MEMWRITE)
                        mem[cur_instr.addr] <= cur_instr.wdata;
                end else begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept)
            cur_instr <= grant_update ? update_instruction : draw_instruction;
        if (busy && !exec_cnt) begin
            if (cur_instr.opcode == OP_MEMREAD)
                result_dp <= mem[cur_instr.addr];
            pixel_x      <= cur_instr.draw_x;
            pixel_y      <= cur_instr.draw_y;
            pixel_colour <= cur_instr.draw_colour;
        end
    end

    // A finish only reaches a client that has dropped its request and is waiting
    assert property (@(posedge clock) disable iff (!resetn)
        !(draw_finished_dp && draw_start_dp) && !(update_finished_dp && update_start_dp));

endmodule

// ==== ant_sim_top.sv ====
`timescale 1ns/10ps
`include "ant_sim_defines.svh"

module ant_sim_top (
    input  logic                      clock,
    input  logic                      resetn,
    input  logic                      draw_start,
    input  logic [`ID_WIDTH-1:0]      draw_id,
    output logic                      draw_finished,
    input  logic                      update_start,
    input  logic [`ID_WIDTH-1:0]      update_id,
    input  logic [3:0]                move_request,
    output logic                      update_finished,
    output logic                      pixel_valid,
    output logic [`X_COORD_WIDTH-1:0] pixel_x,
    output logic [`Y_COORD_WIDTH-1:0] pixel_y,
    output logic [`COLOUR_WIDTH-1:0]  pixel_colour
);
    import ant_sim_pkg::*;

    logic                     draw_start_dp;
    logic                     draw_finished_dp;
    instr_t                   draw_instruction;
    logic                     update_start_dp;
    logic                     update_finished_dp;
    instr_t                   update_instruction;
    // Shared by both clients, each qualifies it with its own finished_dp
    logic [`RESULT_WIDTH-1:0] result_dp;

    ant_draw u_draw (
        .clock          (clock),
        .resetn         (resetn),
        .start          (draw_start),
        .id             (draw_id),
        .finished       (draw_finished),
        .finished_dp    (draw_finished_dp),
        .result_dp      (result_dp),
        .start_dp       (draw_start_dp),
        .instruction_dp (draw_instruction)
    );

    ant_update u_update (
        .clock          (clock),
        .resetn         (resetn),
        .start          (update_start),
        .id             (update_id),
        .move_request   (move_request),
        .finished       (update_finished),
        .finished_dp    (update_finished_dp),
        .result_dp      (result_dp),
        .start_dp       (update_start_dp),
        .instruction_dp (update_instruction)
    );

    ant_datapath u_datapath (
        .clock              (clock),
        .resetn             (resetn),
        .draw_start_dp      (draw_start_dp),
        .draw_instruction   (draw_instruction),
        .draw_finished_dp   (draw_finished_dp),
        .update_start_dp    (update_start_dp),
        .update_instruction (update_instruction),
        .update_finished_dp (update_finished_dp),
        .result_dp          (result_dp),
        .pixel_valid        (pixel_valid),
        .pixel_x            (pixel_x),
        .pixel_y            (pixel_y),
        .pixel_colour       (pixel_colour)
    );

endmodule

// ==== ant_sim_checker.sv ====
`timescale 1ns/10ps
`include "ant_sim_defines.svh"

module ant_sim_checker #(
    parameter int STALL_LIMIT = 150
) (
    input  logic                      clock,
    input  logic                      resetn,
    input  logic                      test_start,
    input  logic                      test_done,
    input  logic                      do_draw,
    input  logic                      do_update,
    input  logic [15:0]               test_num,
    input  logic [`X_COORD_WIDTH-1:0] exp_x,
    input  logic [`Y_COORD_WIDTH-1:0] exp_y,
    input  logic                      draw_finished,
    input  logic                      update_finished,
    input  logic                      pixel_valid,
    input  logic [`X_COORD_WIDTH-1:0] pixel_x,
    input  logic [`Y_COORD_WIDTH-1:0] pixel_y,
    input  logic [`COLOUR_WIDTH-1:0]  pixel_colour,
    output int                        errors,
    output int                        tests_run,
    output int                        tests_failed,
    output logic                      stalled
);
    int   pix_count;
    int   wait_cycles;
    int   errors_at_start;
    int   want_x;
    int   want_y;
    logic active;
    logic check_fall;

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        errors++;
    endtask

    always @(posedge clock) begin
        if (!resetn) begin
            errors       = 0;
            tests_run    = 0;
            tests_failed = 0;
            active       = 1'b0;
            check_fall   = 1'b0;
            stalled     <= 1'b0;
        end else begin
            // One cycle after start, each started client must show busy
            if (check_fall) begin
                check_fall = 1'b0;
                if (draw_finished == do_draw)
                    report_mismatch($sformatf("test %0d draw_finished is %0b after start",
                                              test_num, draw_finished));
                if (update_finished == do_update)
                    report_mismatch($sformatf("test %0d update_finished is %0b after start",
                                              test_num, update_finished));
            end
            if (test_start) begin
                if (!(draw_finished && update_finished))
                    report_mismatch($sformatf("test %0d finished outputs not high at start",
                                              test_num));
                active          = 1'b1;
                check_fall      = 1'b1;
                pix_count       = 0;
                wait_cycles     = 0;
                errors_at_start = errors;
            end
            if (pixel_valid) begin
                if (!active || !do_draw) begin
                    report_mismatch($sformatf("pixel (%0d,%0d) outside any draw",
                                              pixel_x, pixel_y));
                end else if (pix_count >= `ANT_WIDTH * `ANT_HEIGHT) begin
                    report_mismatch($sformatf("test %0d extra pixel (%0d,%0d)",
                                              test_num, pixel_x, pixel_y));
                end else begin
                    // Row by row with x fastest
                    want_x = exp_x + (pix_count % `ANT_WIDTH);
                    want_y = exp_y + (pix_count / `ANT_WIDTH);
                    if (pixel_x != want_x || pixel_y != want_y ||
                        pixel_colour != `ANT_COLOUR)
                        report_mismatch($sformatf(
                            "test %0d pixel %0d is (%0d,%0d) colour %0d, expected (%0d,%0d) colour %0d",
                            test_num, pix_count, pixel_x, pixel_y, pixel_colour,
                            want_x, want_y, `ANT_COLOUR));
                end
                pix_count++;
            end
            if (active) begin
                wait_cycles++;
                if (wait_cycles > STALL_LIMIT && !stalled) begin
                    $display("Test %0d: the operation never finished within %0d cycles",
                             test_num, STALL_LIMIT);
                    errors++;
                    stalled <= 1'b1;
                end
            end
            if (test_done && active) begin
                active = 1'b0;
                if (do_draw && pix_count != `ANT_WIDTH * `ANT_HEIGHT) begin
                    $display("Test %0d: only %0d of %0d pixels were drawn",
                             test_num, pix_count, `ANT_WIDTH * `ANT_HEIGHT);
                    errors++;
                end
                tests_run++;
                if (errors != errors_at_start) begin
                    tests_failed++;
                    $display("Test %0d (draw %0b, update %0b) failed", test_num, do_draw,
                             do_update);
                end else begin
                    $display("Test %0d (draw %0b, update %0b) passed", test_num, do_draw,
                             do_update);
                end
            end
        end
    end

endmodule

// ==== tb_ant_sim.sv ====
`timescale 1ns/10ps
`include "ant_sim_defines.svh"

module tb_ant_sim;

    localparam int KIND_DRAW      = 0;
    localparam int KIND_UPDATE    = 1;
    localparam int KIND_BOTH      = 2;
    localparam int NUM_RANDOM     = 24;
    localparam int CYCLES_PER_ROW = 200;

    typedef struct {
        int         kind;
        int         draw_id;
        int         update_id;
        logic [3:0] move;
        int         repeats;
        int         exp_x;
        int         exp_y;
    } row_t;

    logic                      clock;
    logic                      resetn;
    logic                      draw_start;
    logic [`ID_WIDTH-1:0]      draw_id;
    logic                      draw_finished;
    logic                      update_start;
    logic [`ID_WIDTH-1:0]      update_id;
    logic [3:0]                move_request;
    logic                      update_finished;
    logic                      pixel_valid;
    logic [`X_COORD_WIDTH-1:0] pixel_x;
    logic [`Y_COORD_WIDTH-1:0] pixel_y;
    logic [`COLOUR_WIDTH-1:0]  pixel_colour;

    logic                      test_start;
    logic                      test_done;
    logic                      do_draw;
    logic                      do_update;
    logic [15:0]               test_num;
    logic [`X_COORD_WIDTH-1:0] exp_x;
    logic [`Y_COORD_WIDTH-1:0] exp_y;
    int                        errors;
    int                        tests_run;
    int                        tests_failed;
    logic                      stalled;

    row_t                      rows[$];
    int                        test_count = 0;
    int                        run_cycles = 0;
    // Reference positions of every ant
    logic [`X_COORD_WIDTH-1:0] pos_x [0:`NUM_ANT-1];
    logic [`Y_COORD_WIDTH-1:0] pos_y [0:`NUM_ANT-1];

    ant_sim_top UUT (
        .clock           (clock),
        .resetn          (resetn),
        .draw_start      (draw_start),
        .draw_id         (draw_id),
        .draw_finished   (draw_finished),
        .update_start    (update_start),
        .update_id       (update_id),
        .move_request    (move_request),
        .update_finished (update_finished),
        .pixel_valid     (pixel_valid),
        .pixel_x         (pixel_x),
        .pixel_y         (pixel_y),
        .pixel_colour    (pixel_colour)
    );

    ant_sim_checker u_checker (
        .clock           (clock),
        .resetn          (resetn),
        .test_start      (test_start),
        .test_done       (test_done),
        .do_draw         (do_draw),
        .do_update       (do_update),
        .test_num        (test_num),
        .exp_x           (exp_x),
        .exp_y           (exp_y),
        .draw_finished   (draw_finished),
        .update_finished (update_finished),
        .pixel_valid     (pixel_valid),
        .pixel_x         (pixel_x),
        .pixel_y         (pixel_y),
        .pixel_colour    (pixel_colour),
        .errors          (errors),
        .tests_run       (tests_run),
        .tests_failed    (tests_failed),
        .stalled         (stalled)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Clamp rule, right is tested after left has been applied
    function automatic logic [15:0] move_ant(input logic [7:0] x, input logic [7:0] y,
                                             input logic [3:0] m);
        int nx;
        int ny;
        nx = x;
        ny = y;
        if (m[3] && nx > `ANT_WIDTH / 2)
            nx = nx - 1;
        if (m[2] && nx < `SCREEN_WIDTH - `ANT_WIDTH / 2 - 1)
            nx = nx + 1;
        if (m[1] && ny > `ANT_HEIGHT / 2)
            ny = ny - 1;
        if (m[0] && ny < `SCREEN_HEIGHT - `ANT_HEIGHT / 2 - 1)
            ny = ny + 1;
        return {nx[7:0], ny[7:0]};
    endfunction

    task automatic add_row(input int kind, input int did, input int uid, input logic [3:0] m,
                           input int rep, input int ex, input int ey);
        row_t r;
        r.kind      = kind;
        r.draw_id   = did;
        r.update_id = uid;
        r.move      = m;
        r.repeats   = rep;
        r.exp_x     = ex;
        r.exp_y     = ey;
        rows.push_back(r);
    endtask

    // Move bits are left, right, up, down; expected values are the sprite corner
    task automatic fill_table();
        add_row(KIND_DRAW,   0, 0, 4'b0000,  1, 79, 59);
        add_row(KIND_UPDATE, 0, 0, 4'b0101,  1,  0,  0);
        add_row(KIND_DRAW,   0, 0, 4'b0000,  1, 80, 60);
        add_row(KIND_DRAW,   1, 0, 4'b0000,  1, 79, 59);
        add_row(KIND_UPDATE, 0, 1, 4'b0010,  1,  0,  0);
        add_row(KIND_DRAW,   1, 0, 4'b0000,  1, 79, 58);
        add_row(KIND_DRAW,   0, 0, 4'b0000,  1, 80, 60);
        // Draw sees the position from before the update
        add_row(KIND_BOTH,   2, 2, 4'b1000,  1, 79, 59);
        add_row(KIND_DRAW,   2, 0, 4'b0000,  1, 78, 59);
        add_row(KIND_BOTH,   0, 3, 4'b1100,  1, 80, 60);
        add_row(KIND_DRAW,   3, 0, 4'b0000,  1, 79, 59);
        add_row(KIND_UPDATE, 0, 3, 4'b1000, 85,  0,  0);
        add_row(KIND_DRAW,   3, 0, 4'b0000,  1,  0, 59);
        // At the left edge only right applies
        add_row(KIND_UPDATE, 0, 3, 4'b1100,  1,  0,  0);
        add_row(KIND_DRAW,   3, 0, 4'b0000,  1,  1, 59);
    endtask

    task automatic run_test(input int kind, input int did, input int uid, input logic [3:0] m,
                            input logic [7:0] ex, input logic [7:0] ey);
        if (stalled)
            return;
        draw_start   <= (kind != KIND_UPDATE);
        update_start <= (kind != KIND_DRAW);
        draw_id      <= did;
        update_id    <= uid;
        move_request <= m;
        test_start   <= 1'b1;
        do_draw      <= (kind != KIND_UPDATE);
        do_update    <= (kind != KIND_DRAW);
        test_num     <= test_count;
        exp_x        <= ex;
        exp_y        <= ey;
        test_count++;
        @(posedge clock);
        draw_start   <= 1'b0;
        update_start <= 1'b0;
        test_start   <= 1'b0;
        do begin
            @(posedge clock);
        end while (!(draw_finished && update_finished) && !stalled);
        test_done <= 1'b1;
        @(posedge clock);
        test_done <= 1'b0;
        if (kind != KIND_DRAW)
            {pos_x[uid], pos_y[uid]} = move_ant(pos_x[uid], pos_y[uid], m);
    endtask

    initial begin
        int          total_runs;
        int          rid;
        logic [3:0]  rmove;
        logic [31:0] seed;
        resetn       = 1'b0;
        draw_start   = 1'b0;
        draw_id      = '0;
        update_start = 1'b0;
        update_id    = '0;
        move_request = '0;
        test_start   = 1'b0;
        test_done    = 1'b0;
        do_draw      = 1'b0;
        do_update    = 1'b0;
        test_num     = '0;
        exp_x        = '0;
        exp_y        = '0;
        for (int a = 0; a < `NUM_ANT; a++) begin
            pos_x[a] = `ANT_RESET_X;
            pos_y[a] = `ANT_RESET_Y;
        end
        fill_table();
        total_runs = 2 * NUM_RANDOM;
        foreach (rows[r])
            total_runs += rows[r].repeats;
        run_cycles = total_runs * CYCLES_PER_ROW + 20;

        repeat (8) @(posedge clock);
        resetn <= 1'b1;
        @(posedge clock);

        foreach (rows[r]) begin
            for (int k = 0; k < rows[r].repeats; k++)
                run_test(rows[r].kind, rows[r].draw_id, rows[r].update_id, rows[r].move,
                         rows[r].exp_x, rows[r].exp_y);
        end

        // Random moves on random ants, each followed by a draw of that ant
        seed = 32'd90025;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            seed  = xorshift(seed);
            rid   = seed[1:0];
            rmove = seed[7:4];
            run_test(KIND_UPDATE, 0, rid, rmove, 0, 0);
            run_test(KIND_DRAW, rid, 0, 4'b0000, pos_x[rid] - 1, pos_y[rid] - 1);
        end

        repeat (2) @(posedge clock);
        $display("Tests run %0d of %0d, failed %0d, errors %0d", tests_run, total_runs,
                 tests_failed, errors);
        if (errors == 0 && tests_run == total_runs) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        wait (run_cycles > 0);
        repeat (run_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the tests did not complete", run_cycles);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== ant_sim.f ====
+incdir+.
ant_sim_pkg.sv
ant_draw.sv
ant_update.sv
ant_datapath.sv
ant_sim_top.sv
ant_sim_checker.sv
tb_ant_sim.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run the ant simulation testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f ant_sim.f \
    --top-module tb_ant_sim -o sim_ant_sim \
    && ./obj_dir/sim_ant_sim | tee /dev/stderr | grep -q "Everything OK" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
